// ==== logic/ant_pkg.sv ====
package ant_pkg;

    // Coordinate and colour widths
    localparam int x_coord_width = 8;
    localparam int y_coord_width = 7;
    localparam int colour_width  = 3;

    // Ant population
    localparam int num_ants     = 4;
    localparam int ant_id_width = 2;

    // Screen geometry and ant appearance
    localparam int screen_width  = 160;
    localparam int screen_height = 120;
    localparam int ant_size      = 3;
    localparam int colour_ant    = 6;

    typedef logic [x_coord_width-1:0] ant_x_t;
    typedef logic [y_coord_width-1:0] ant_y_t;
    typedef logic [ant_id_width-1:0]  ant_id_t;
    typedef logic [colour_width-1:0]  colour_t;

    typedef enum logic {
        op_update,
        op_draw
    } ant_op_t;

    typedef struct packed {
        ant_op_t op;
        ant_id_t id;
    } ant_cmd_t;

    // Heading bits are set when the ant moves left or up
    typedef struct packed {
        ant_x_t x;
        ant_y_t y;
        logic   x_back;
        logic   y_back;
    } ant_record_t;

    typedef enum logic [1:0] {
        opcode_read,
        opcode_write,
        opcode_draw
    } opcode_t;

    // Memory instructions address a record, draw instructions carry a pixel
    typedef union packed {
        struct packed {
            ant_id_t     id;
            ant_record_t rec;
            logic        spare;
        } mem;
        struct packed {
            ant_x_t     x;
            ant_y_t     y;
            colour_t    colour;
            logic [1:0] spare;
        } draw;
    } instr_body_t;

    typedef struct packed {
        opcode_t     opcode;
        instr_body_t body;
    } dp_req_t;

    typedef struct packed {
        ant_x_t  x;
        ant_y_t  y;
        colour_t colour;
    } pixel_t;

    // Ants start spread along a diagonal
    function automatic ant_x_t reset_x(int i);
        return ant_x_t'(10 + 16 * i);
    endfunction

    function automatic ant_y_t reset_y(int i);
        return ant_y_t'(10 + 8 * i);
    endfunction

endpackage

// ==== logic/ant_memory_datapath.sv ====
module ant_memory_datapath (
    input  logic                 clock,
    input  logic                 resetn,
    input  ant_pkg::dp_req_t     req,
    input  logic                 req_valid,
    output logic                 done,
    output ant_pkg::ant_record_t rdata,
    output ant_pkg::pixel_t      pixel,
    output logic                 pixel_valid,
    input  logic                 pixel_ready
);
    import ant_pkg::*;

    ant_record_t ants [num_ants];
    logic        mem_done;
    logic        accept;
    logic        is_draw;
    logic        pixel_fire;

    // A new instruction is taken only when nothing is outstanding
    assign accept     = req_valid && !mem_done && !pixel_valid;
    assign is_draw    = (req.opcode == opcode_draw);
    assign pixel_fire = pixel_valid && pixel_ready;

    // Draws complete on the pixel handshake, memory ops one cycle after accept
    assign done = mem_done || pixel_fire;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            mem_done    <= 1'b0;
            pixel_valid <= 1'b0;
            for (int i = 0; i < num_ants; i++) begin
                ants[i] <= '{
                    x:      reset_x(i),
                    y:      reset_y(i),
                    x_back: 1'b0,
                    y_back: 1'b0
                };
            end
        end else begin
            mem_done <= accept && !is_draw;

            if (pixel_fire) begin
                pixel_valid <= 1'b0;
            end else if (accept && is_draw) begin
                pixel_valid <= 1'b1;
            end

            if (accept && req.opcode == opcode_write) begin
                ants[req.body.mem.id] <= req.body.mem.rec;
            end
        end
    end

    // Read data and pixel word stay put until the next instruction of the same kind
    always_ff @(posedge clock) begin
        if (accept) begin
            if (is_draw) begin
                pixel.x      <= req.body.draw.x;
                pixel.y      <= req.body.draw.y;
                pixel.colour <= req.body.draw.colour;
            end else if (req.opcode == opcode_read) begin
                rdata <= ants[req.body.mem.id];
            end
        end
    end

endmodule

// ==== logic/datapath_arbiter.sv ====
module datapath_arbiter (
    input  logic                 clock,
    input  logic                 resetn,
    input  ant_pkg::dp_req_t     upd_req,
    input  ant_pkg::dp_req_t     draw_req,
    input  logic                 upd_valid,
    input  logic                 draw_valid,
    output logic                 upd_done,
    output logic                 draw_done,
    output ant_pkg::ant_record_t rdata_out,
    output ant_pkg::dp_req_t     dp_req,
    output logic                 dp_valid,
    input  logic                 dp_done,
    input  ant_pkg::ant_record_t dp_rdata
);

    logic locked;
    logic owner;
    logic prio_draw;
    logic sel;

    // sel is 1 for the draw controller, 0 for the update controller
    always_comb begin
        if (locked) begin
            sel = owner;
        end else if (upd_valid && draw_valid) begin
            sel = prio_draw;
        end else begin
            sel = draw_valid;
        end
    end

    assign dp_valid  = sel ? draw_valid : upd_valid;
    assign dp_req    = sel ? draw_req : upd_req;
    assign upd_done  = dp_done && !sel;
    assign draw_done = dp_done && sel;
    assign rdata_out = dp_rdata;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            locked    <= 1'b0;
            owner     <= 1'b0;
            prio_draw <= 1'b0;
        end else if (dp_done) begin
            // Release and hand priority to the other side
            locked    <= 1'b0;
            prio_draw <= !sel;
        end else if (dp_valid && !locked) begin
            locked <= 1'b1;
            owner  <= sel;
        end
    end

endmodule

// ==== logic/ant_update_fsm.sv ====
module ant_update_fsm (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 start,
    input  ant_pkg::ant_id_t     id,
    output logic                 idle,
    output ant_pkg::dp_req_t     req,
    output logic                 req_valid,
    input  logic                 done,
    input  ant_pkg::ant_record_t rdata
);
    import ant_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read_x,
        st_read_y,
        st_move,
        st_write_x,
        st_write_y
    } state_t;

    state_t      state;
    ant_id_t     cur_id;
    ant_record_t cur;
    ant_record_t nxt;
    ant_x_t      step_x;
    ant_y_t      step_y;

    // One pixel along the current heading
    assign step_x = cur.x_back ? cur.x - ant_x_t'(1) : cur.x + ant_x_t'(1);
    assign step_y = cur.y_back ? cur.y - ant_y_t'(1) : cur.y + ant_y_t'(1);

    assign idle      = (state == st_idle);
    assign req_valid = state inside {st_read_x, st_read_y, st_write_x, st_write_y};

    always_comb begin
        req = '0;
        req.opcode = opcode_read;
        req.body.mem.id = cur_id;
        if (state == st_write_x) begin
            // X half goes out first, y still holds the loaded value
            req.opcode = opcode_write;
            req.body.mem.rec = cur;
            req.body.mem.rec.x = nxt.x;
            req.body.mem.rec.x_back = nxt.x_back;
        end else if (state == st_write_y) begin
            req.opcode = opcode_write;
            req.body.mem.rec = nxt;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (start) state <= st_read_x;
                st_read_x:  if (done) state <= st_read_y;
                st_read_y:  if (done) state <= st_move;
                st_move:    state <= st_write_x;
                st_write_x: if (done) state <= st_write_y;
                st_write_y: if (done) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (idle && start) begin
            cur_id <= id;
        end
        if (done && state == st_read_x) begin
            cur.x      <= rdata.x;
            cur.x_back <= rdata.x_back;
        end
        if (done && state == st_read_y) begin
            cur.y      <= rdata.y;
            cur.y_back <= rdata.y_back;
        end
        if (state == st_move) begin
            nxt.x <= step_x;
            nxt.y <= step_y;
            // Bounce off the screen edges
            if (step_x == '0) begin
                nxt.x_back <= 1'b0;
            end else if (step_x == ant_x_t'(screen_width - ant_size)) begin
                nxt.x_back <= 1'b1;
            end else begin
                nxt.x_back <= cur.x_back;
            end
            if (step_y == '0) begin
                nxt.y_back <= 1'b0;
            end else if (step_y == ant_y_t'(screen_height - ant_size)) begin
                nxt.y_back <= 1'b1;
            end else begin
                nxt.y_back <= cur.y_back;
            end
        end
    end

endmodule

// ==== logic/ant_draw_fsm.sv ====
module ant_draw_fsm (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 start,
    input  ant_pkg::ant_id_t     id,
    output logic                 idle,
    output ant_pkg::dp_req_t     req,
    output logic                 req_valid,
    input  logic                 done,
    input  ant_pkg::ant_record_t rdata
);
    import ant_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_emit
    } state_t;

    typedef logic [$clog2(ant_size)-1:0] step_t;

    state_t  state;
    ant_id_t cur_id;
    ant_x_t  base_x;
    ant_y_t  base_y;
    step_t   dx;
    step_t   dy;
    logic    last_x;
    logic    last_y;

    assign idle      = (state == st_idle);
    assign req_valid = (state != st_idle);
    assign last_x    = (dx == step_t'(ant_size - 1));
    assign last_y    = (dy == step_t'(ant_size - 1));

    // Block is centred on the ant, so offsets start one pixel up and left
    always_comb begin
        req = '0;
        req.opcode = opcode_read;
        req.body.mem.id = cur_id;
        if (state == st_emit) begin
            req.body = '0;
            req.opcode = opcode_draw;
            req.body.draw.x = base_x + ant_x_t'(dx) - ant_x_t'(1);
            req.body.draw.y = base_y + ant_y_t'(dy) - ant_y_t'(1);
            req.body.draw.colour = colour_t'(colour_ant);
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_idle;
            dx    <= '0;
            dy    <= '0;
        end else begin
            case (state)
                st_idle: if (start) state <= st_load;
                st_load: if (done) state <= st_emit;
                st_emit: begin
                    // Raster order, x fastest
                    if (done) begin
                        if (last_x) begin
                            dx <= '0;
                            if (last_y) begin
                                dy    <= '0;
                                state <= st_idle;
                            end else begin
                                dy <= dy + step_t'(1);
                            end
                        end else begin
                            dx <= dx + step_t'(1);
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (idle && start) begin
            cur_id <= id;
        end
        if (done && state == st_load) begin
            base_x <= rdata.x;
            base_y <= rdata.y;
        end
    end

endmodule

// ==== logic/ant_sim_top.sv ====
module ant_sim_top (
    input  logic              clock,
    input  logic              resetn,
    input  ant_pkg::ant_cmd_t cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output ant_pkg::pixel_t   pixel,
    output logic              pixel_valid,
    input  logic              pixel_ready
);
    import ant_pkg::*;

    logic        upd_start;
    logic        draw_start;
    logic        upd_idle;
    logic        draw_idle;
    dp_req_t     upd_req;
    dp_req_t     draw_req;
    logic        upd_valid;
    logic        draw_valid;
    logic        upd_done;
    logic        draw_done;
    ant_record_t arb_rdata;
    dp_req_t     dp_req;
    logic        dp_valid;
    logic        dp_done;
    ant_record_t dp_rdata;

    // Each command goes to its own controller, so both kinds may overlap
    assign upd_start  = cmd_valid && (cmd.op == op_update);
    assign draw_start = cmd_valid && (cmd.op == op_draw);
    assign cmd_ready  = (cmd.op == op_update) ? upd_idle : draw_idle;

    ant_update_fsm u_update (
        .clock(clock), .resetn(resetn), .start(upd_start), .id(cmd.id),
        .idle(upd_idle), .req(upd_req), .req_valid(upd_valid),
        .done(upd_done), .rdata(arb_rdata)
    );

    ant_draw_fsm u_draw (
        .clock(clock), .resetn(resetn), .start(draw_start), .id(cmd.id),
        .idle(draw_idle), .req(draw_req), .req_valid(draw_valid),
        .done(draw_done), .rdata(arb_rdata)
    );

    datapath_arbiter u_arbiter (
        .clock(clock), .resetn(resetn),
        .upd_req(upd_req), .draw_req(draw_req),
        .upd_valid(upd_valid), .draw_valid(draw_valid),
        .upd_done(upd_done), .draw_done(draw_done), .rdata_out(arb_rdata),
        .dp_req(dp_req), .dp_valid(dp_valid), .dp_done(dp_done), .dp_rdata(dp_rdata)
    );

    ant_memory_datapath u_datapath (
        .clock(clock), .resetn(resetn), .req(dp_req), .req_valid(dp_valid),
        .done(dp_done), .rdata(dp_rdata), .pixel(pixel),
        .pixel_valid(pixel_valid), .pixel_ready(pixel_ready)
    );

endmodule

// ==== test/ant_sim_checker.sv ====
module ant_sim_checker (
    input  logic              clock,
    input  logic              resetn,
    input  logic              cmd_ready,
    input  ant_pkg::pixel_t   pixel,
    input  logic              pixel_valid,
    input  logic              pixel_ready
);
    timeunit 1ns;
    timeprecision 100ps;
    import ant_pkg::*;

    int fail_count = 0;

    // A stalled pixel keeps its word until the sink takes it
    a_pixel_hold: assert property (@(posedge clock) disable iff (!resetn)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel))
    else begin
        fail_count++;
        $error("pixel changed or dropped while pixel_ready was low");
    end

    a_pixel_on_screen: assert property (@(posedge clock) disable iff (!resetn)
        pixel_valid |-> pixel.x < ant_x_t'(screen_width) && pixel.y < ant_y_t'(screen_height))
    else begin
        fail_count++;
        $error("pixel outside the screen");
    end

    a_ready_after_reset: assert property (@(posedge clock) $rose(resetn) |-> cmd_ready)
    else begin
        fail_count++;
        $error("cmd_ready low right after reset");
    end

    a_quiet_in_reset: assert property (@(posedge clock) !resetn |=> !pixel_valid)
    else begin
        fail_count++;
        $error("pixel_valid high after a reset cycle");
    end

endmodule

bind ant_sim_top ant_sim_checker checker_i (.*);

// ==== test/ant_sim_tb.sv ====
module ant_sim_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ant_pkg::*;

    // Walk of ant 3 to the bottom edge is about 90 updates of 15 cycles,
    // the remaining draws and the stall add a few hundred more
    localparam int max_cycles = 4000;

    logic     clock = 1'b0;
    logic     resetn;
    ant_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    pixel_t   pixel;
    logic     pixel_valid;
    logic     pixel_ready;

    integer   seed = 84487;
    logic     throttle;
    int       cycles = 0;
    int       errors = 0;
    int       tests = 0;
    int       fail_mark = 0;
    int       y_first;
    int       y_second;
    pixel_t   pix_q[$];
    int       model_x [num_ants];
    int       model_y [num_ants];
    logic     model_xb [num_ants];
    logic     model_yb [num_ants];

    ant_sim_top dut_i (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Random back-pressure on the pixel sink
    always @(posedge clock) begin
        #1;
        if (throttle) begin
            pixel_ready = ($random(seed) & 3) != 0;
        end
    end

    always @(negedge clock) begin
        if (resetn && pixel_valid && pixel_ready) begin
            pix_q.push_back(pixel);
        end
    end

    function automatic int total_fails();
        return errors + dut_i.checker_i.fail_count;
    endfunction

    function automatic void check_value(string name, int got, int exp);
        assert (got == exp) else begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endfunction

    // Step one pixel along the heading and bounce at the edges
    function automatic void model_step(int id);
        model_x[id] = model_xb[id] ? model_x[id] - 1 : model_x[id] + 1;
        model_y[id] = model_yb[id] ? model_y[id] - 1 : model_y[id] + 1;
        if (model_x[id] == 0) model_xb[id] = 1'b0;
        else if (model_x[id] == screen_width - ant_size) model_xb[id] = 1'b1;
        if (model_y[id] == 0) model_yb[id] = 1'b0;
        else if (model_y[id] == screen_height - ant_size) model_yb[id] = 1'b1;
    endfunction

    task automatic send_cmd(ant_op_t op, int id);
        cmd.op = op;
        cmd.id = ant_id_t'(id);
        cmd_valid = 1'b1;
        @(negedge clock);
        while (!cmd_ready) @(negedge clock);
        @(posedge clock);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_update_idle();
        cmd.op = op_update;
        @(negedge clock);
        while (!cmd_ready) @(negedge clock);
        @(posedge clock);
        #1;
    endtask

    task automatic run_update(int id);
        send_cmd(op_update, id);
        wait_update_idle();
        model_step(id);
    endtask

    task automatic start_draw(int id);
        pix_q.delete();
        send_cmd(op_draw, id);
    endtask

    // Nine pixels in raster order around the model position
    task automatic check_draw(int id, output int centre_y);
        while (pix_q.size() < 9) @(posedge clock);
        repeat (2) @(posedge clock);
        #1;
        check_value("pixel count", pix_q.size(), 9);
        for (int i = 0; i < 9; i++) begin
            check_value("pixel.x", int'(pix_q[i].x), model_x[id] - 1 + i % 3);
            check_value("pixel.y", int'(pix_q[i].y), model_y[id] - 1 + i / 3);
            check_value("pixel.colour", int'(pix_q[i].colour), colour_ant);
        end
        centre_y = int'(pix_q[4].y);
    endtask

    task automatic finish_test(string name);
        tests++;
        if (total_fails() == fail_mark) $display("Test %0d %s: ok", tests, name);
        else $display("Test %0d %s: %0d failures", tests, name, total_fails() - fail_mark);
        fail_mark = total_fails();
    endtask

    initial begin
        resetn = 1'b0;
        cmd = '0;
        cmd_valid = 1'b0;
        pixel_ready = 1'b0;
        throttle = 1'b0;
        for (int i = 0; i < num_ants; i++) begin
            model_x[i] = 10 + 16 * i;
            model_y[i] = 10 + 8 * i;
            model_xb[i] = 1'b0;
            model_yb[i] = 1'b0;
        end
        repeat (4) @(posedge clock);
        #1;
        resetn = 1'b1;

        @(negedge clock);
        check_value("cmd_ready", cmd_ready, 1);
        check_value("pixel_valid", pixel_valid, 0);
        @(posedge clock);
        #1;
        cmd.op = op_draw;
        @(negedge clock);
        check_value("cmd_ready", cmd_ready, 1);
        @(posedge clock);
        #1;
        throttle = 1'b1;
        start_draw(0);
        check_draw(0, y_first);
        finish_test("draw after reset");

        repeat (5) run_update(1);
        start_draw(1);
        check_draw(1, y_first);
        finish_test("updates then draw");

        for (int n = 0; n < 100 && !model_yb[3]; n++) begin
            run_update(3);
        end
        start_draw(3);
        check_draw(3, y_first);
        run_update(3);
        start_draw(3);
        check_draw(3, y_second);
        assert (y_second < y_first) else begin
            $display("Ant 3 did not move up after the bottom edge");
            errors++;
        end
        finish_test("bounce at bottom edge");

        throttle = 1'b0;
        pixel_ready = 1'b0;
        start_draw(2);
        repeat (12) @(posedge clock);
        #1;
        // The stalled word is the first pixel of the block
        check_value("pixel_valid", pixel_valid, 1);
        check_value("pixel.x", int'(pixel.x), model_x[2] - 1);
        check_value("pixel.y", int'(pixel.y), model_y[2] - 1);
        throttle = 1'b1;
        check_draw(2, y_first);
        finish_test("pixel back-pressure");

        start_draw(0);
        cmd.op = op_update;
        cmd.id = ant_id_t'(2);
        cmd_valid = 1'b1;
        @(negedge clock);
        check_value("cmd_ready", cmd_ready, 1);
        @(posedge clock);
        #1;
        cmd_valid = 1'b0;
        wait_update_idle();
        model_step(2);
        check_draw(0, y_first);
        start_draw(2);
        check_draw(2, y_first);
        finish_test("update during draw");

        $display("%0d tests run, %0d checks failed", tests, total_fails());
        if (total_fails() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/ant_pkg.sv
logic/ant_memory_datapath.sv
logic/datapath_arbiter.sv
logic/ant_update_fsm.sv
logic/ant_draw_fsm.sv
logic/ant_sim_top.sv
test/ant_sim_checker.sv
test/ant_sim_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = ant_sim_tb
FILELIST  = sources.f
PASS_TEXT = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
